// ==== Makefile ====
# Verilator lint and simulation of the datapath
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
FILELIST  ?= datapath.f
TB_TOP    ?= datapath_tb
RTL_TOP   ?= datapath
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# Builds the testbench, runs it and passes only when the pass line shows up
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== datapath.f ====
+incdir+logic
logic/datapath_pkg.sv
logic/io_predication.sv
logic/operand_bank.sv
logic/alu.sv
logic/datapath.sv
tests/datapath_tb.sv

// ==== logic/alu.sv ====
// Flags cover add and sub only; logic ops and pass_a clear carry and overflow
`timescale 1ns/1ns
`default_nettype none

`include "datapath_cfg.svh"

module alu (
    input  wire                           clock,
    input  wire                           arst_n,
    input  wire datapath_pkg::alu_op_e    control_s1,
    input  wire                           io_ready,
    input  wire datapath_pkg::addr_t      write_addr_a_s1,
    input  wire datapath_pkg::addr_t      write_addr_b_s1,
    input  wire datapath_pkg::port_mask_t wr_mask_a,
    input  wire datapath_pkg::port_mask_t wr_mask_b,
    input  wire datapath_pkg::word_t      operand_a,
    input  wire datapath_pkg::word_t      operand_b,
    output datapath_pkg::word_t           r,
    output logic                          r_carry,
    output logic                          r_overflow,
    output logic                          r_valid,
    output datapath_pkg::addr_t           r_write_addr_a,
    output datapath_pkg::addr_t           r_write_addr_b,
    output datapath_pkg::port_mask_t      io_wren_a,
    output datapath_pkg::port_mask_t      io_wren_b
);

    import datapath_pkg::*;

    localparam int MSB = `DP_WORD_WIDTH - 1;

    alu_op_e    control_s2;
    logic       ready_s2;
    addr_t      write_addr_a_s2;
    addr_t      write_addr_b_s2;
    port_mask_t wr_mask_a_s2;
    port_mask_t wr_mask_b_s2;

    logic [`DP_WORD_WIDTH:0] sum;
    word_t                   result;
    logic                    carry;
    logic                    overflow;

    // --------------------------------------------------
    // Stage 2, line up with the operands from the banks

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ready_s2     <= 1'b0;
            wr_mask_a_s2 <= '0;
            wr_mask_b_s2 <= '0;
        end else begin
            ready_s2     <= io_ready;
            wr_mask_a_s2 <= wr_mask_a;
            wr_mask_b_s2 <= wr_mask_b;
        end
    end

    always_ff @(posedge clock) begin
        control_s2      <= control_s1;
        write_addr_a_s2 <= write_addr_a_s1;
        write_addr_b_s2 <= write_addr_b_s1;
    end

    always_comb begin
        sum      = '0;
        result   = '0;
        carry    = 1'b0;
        overflow = 1'b0;
        case (control_s2)
            ALU_ADD: begin
                sum      = {1'b0, operand_a} + {1'b0, operand_b};
                result   = sum[MSB:0];
                carry    = sum[MSB+1];
                overflow = (operand_a[MSB] == operand_b[MSB]) && (result[MSB] != operand_a[MSB]);
            end
            ALU_SUB: begin
                // a + ~b + 1, so carry set means no borrow
                sum      = {1'b0, operand_a} + {1'b0, ~operand_b} + 1'b1;
                result   = sum[MSB:0];
                carry    = sum[MSB+1];
                overflow = (operand_a[MSB] != operand_b[MSB]) && (result[MSB] != operand_a[MSB]);
            end
            ALU_AND:    result = operand_a & operand_b;
            ALU_OR:     result = operand_a | operand_b;
            ALU_XOR:    result = operand_a ^ operand_b;
            ALU_PASS_A: result = operand_a;
            default:    result = '0;
        endcase
    end

    // --------------------------------------------------
    // Stage 3, outputs to write-back and the ports

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            r              <= '0;
            r_carry        <= 1'b0;
            r_overflow     <= 1'b0;
            r_valid        <= 1'b0;
            r_write_addr_a <= '0;
            r_write_addr_b <= '0;
            io_wren_a      <= '0;
            io_wren_b      <= '0;
        end else begin
            r              <= result;
            r_carry        <= carry;
            r_overflow     <= overflow;
            r_valid        <= ready_s2;
            r_write_addr_a <= write_addr_a_s2;
            r_write_addr_b <= write_addr_b_s2;
            io_wren_a      <= wr_mask_a_s2;
            io_wren_b      <= wr_mask_b_s2;
        end
    end

    // Predicated instructions must carry a real opcode from upstream
    control_defined : assert property (
        @(posedge clock) disable iff (!arst_n)
        io_ready |-> (control_s1 inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_A})
    );

endmodule

`default_nettype wire

// ==== logic/datapath.sv ====
// Three-edge issue-to-result latency, no stall; upstream must reissue any instruction annulled here
`timescale 1ns/1ns
`default_nettype none

`include "datapath_cfg.svh"

module datapath (
    input  wire                                              clock,
    input  wire                                              arst_n,
    input  wire datapath_pkg::alu_op_e                       control,
    input  wire                                              cancel,
    input  wire datapath_pkg::addr_t                         read_addr_a,
    input  wire datapath_pkg::addr_t                         read_addr_b,
    input  wire datapath_pkg::addr_t                         write_addr_a,
    input  wire datapath_pkg::addr_t                         write_addr_b,
    input  wire datapath_pkg::port_mask_t                    io_read_ef_a,
    input  wire datapath_pkg::port_mask_t                    io_read_ef_b,
    input  wire datapath_pkg::port_mask_t                    io_write_ef_a,
    input  wire datapath_pkg::port_mask_t                    io_write_ef_b,
    input  wire datapath_pkg::word_t [`DP_IO_PORT_COUNT-1:0] io_read_data_a,
    input  wire datapath_pkg::word_t [`DP_IO_PORT_COUNT-1:0] io_read_data_b,
    output wire                                              io_ready,
    output wire datapath_pkg::port_mask_t                    io_rden_a,
    output wire datapath_pkg::port_mask_t                    io_rden_b,
    output wire datapath_pkg::port_mask_t                    io_wren_a,
    output wire datapath_pkg::port_mask_t                    io_wren_b,
    output wire datapath_pkg::word_t [`DP_IO_PORT_COUNT-1:0] io_write_data_a,
    output wire datapath_pkg::word_t [`DP_IO_PORT_COUNT-1:0] io_write_data_b,
    output wire datapath_pkg::word_t                         r,
    output wire                                              r_valid,
    output wire                                              r_carry,
    output wire                                              r_overflow,
    output wire datapath_pkg::addr_t                         r_write_addr_a,
    output wire datapath_pkg::addr_t                         r_write_addr_b
);

    import datapath_pkg::*;

    port_mask_t wr_mask_a;
    port_mask_t wr_mask_b;
    alu_op_e    control_s1;
    addr_t      read_addr_a_s1;
    addr_t      read_addr_b_s1;
    addr_t      write_addr_a_s1;
    addr_t      write_addr_b_s1;
    word_t      operand_a;
    word_t      operand_b;

    // --------------------------------------------------
    // Stage 1, predication

    io_predication u_io_predication (
        .clock           (clock),
        .arst_n          (arst_n),
        .cancel          (cancel),
        .control         (control),
        .read_addr_a     (read_addr_a),
        .read_addr_b     (read_addr_b),
        .write_addr_a    (write_addr_a),
        .write_addr_b    (write_addr_b),
        .io_read_ef_a    (io_read_ef_a),
        .io_read_ef_b    (io_read_ef_b),
        .io_write_ef_a   (io_write_ef_a),
        .io_write_ef_b   (io_write_ef_b),
        .io_ready        (io_ready),
        .io_rden_a       (io_rden_a),
        .io_rden_b       (io_rden_b),
        .wr_mask_a       (wr_mask_a),
        .wr_mask_b       (wr_mask_b),
        .control_s1      (control_s1),
        .read_addr_a_s1  (read_addr_a_s1),
        .read_addr_b_s1  (read_addr_b_s1),
        .write_addr_a_s1 (write_addr_a_s1),
        .write_addr_b_s1 (write_addr_b_s1)
    );

    // --------------------------------------------------
    // Stage 2 reads and write-back, one bank per side

    operand_bank u_bank_a (
        .clock         (clock),
        .arst_n        (arst_n),
        .read_addr     (read_addr_a_s1),
        .io_rden       (io_rden_a),
        .io_read_data  (io_read_data_a),
        .r             (r),
        .write_addr    (r_write_addr_a),
        .r_valid       (r_valid),
        .io_wren       (io_wren_a),
        .operand       (operand_a),
        .io_write_data (io_write_data_a)
    );

    operand_bank u_bank_b (
        .clock         (clock),
        .arst_n        (arst_n),
        .read_addr     (read_addr_b_s1),
        .io_rden       (io_rden_b),
        .io_read_data  (io_read_data_b),
        .r             (r),
        .write_addr    (r_write_addr_b),
        .r_valid       (r_valid),
        .io_wren       (io_wren_b),
        .operand       (operand_b),
        .io_write_data (io_write_data_b)
    );

    alu u_alu (
        .clock           (clock),
        .arst_n          (arst_n),
        .control_s1      (control_s1),
        .io_ready        (io_ready),
        .write_addr_a_s1 (write_addr_a_s1),
        .write_addr_b_s1 (write_addr_b_s1),
        .wr_mask_a       (wr_mask_a),
        .wr_mask_b       (wr_mask_b),
        .operand_a       (operand_a),
        .operand_b       (operand_b),
        .r               (r),
        .r_carry         (r_carry),
        .r_overflow      (r_overflow),
        .r_valid         (r_valid),
        .r_write_addr_a  (r_write_addr_a),
        .r_write_addr_b  (r_write_addr_b),
        .io_wren_a       (io_wren_a),
        .io_wren_b       (io_wren_b)
    );

endmodule

`default_nettype wire

// ==== logic/datapath_cfg.svh ====
// Sizes are fixed for one build; the port window always sits at the very top of the address map
`ifndef DATAPATH_CFG_SVH
`define DATAPATH_CFG_SVH

// --------------------------------------------------
// Data and address widths

`define DP_WORD_WIDTH 36
`define DP_ADDR_WIDTH 10

// --------------------------------------------------
// I/O ports, same count on the A and B sides

`define DP_IO_PORT_COUNT 4
`define DP_IO_PORT_BITS 2

// Upper address bits that select the port window
// With 10-bit addresses and 2 port bits this maps 1020 to 1023 onto the ports
`define DP_IO_TAG 8'hFF

`endif

// ==== logic/datapath_pkg.sv ====
// Types only; widths come from datapath_cfg.svh, which must sit on the include path
`default_nettype none

`include "datapath_cfg.svh"

package datapath_pkg;

    // --------------------------------------------------
    // Basic datapath words

    typedef logic [`DP_WORD_WIDTH-1:0] word_t;
    typedef logic [`DP_ADDR_WIDTH-1:0] addr_t;

    // One bit per I/O port, zero or one-hot
    typedef logic [`DP_IO_PORT_COUNT-1:0] port_mask_t;

    // --------------------------------------------------
    // ALU operations

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_A = 3'd5
    } alu_op_e;

    // --------------------------------------------------
    // Operand address, seen two ways
    // As a flat memory index, or as tag plus port number inside the I/O window

    typedef union packed {
        addr_t index;
        struct packed {
            logic [`DP_ADDR_WIDTH-`DP_IO_PORT_BITS-1:0] io_tag;
            logic [`DP_IO_PORT_BITS-1:0]                port;
        } io;
    } operand_addr_u;

endpackage

`default_nettype wire

// ==== logic/io_predication.sv ====
// Stage 1 only decodes the port window; an empty or full port annuls the instruction, never stalls
`timescale 1ns/1ns
`default_nettype none

`include "datapath_cfg.svh"

module io_predication (
    input  wire                          clock,
    input  wire                          arst_n,
    input  wire                          cancel,
    input  wire datapath_pkg::alu_op_e   control,
    input  wire datapath_pkg::addr_t     read_addr_a,
    input  wire datapath_pkg::addr_t     read_addr_b,
    input  wire datapath_pkg::addr_t     write_addr_a,
    input  wire datapath_pkg::addr_t     write_addr_b,
    input  wire datapath_pkg::port_mask_t io_read_ef_a,
    input  wire datapath_pkg::port_mask_t io_read_ef_b,
    input  wire datapath_pkg::port_mask_t io_write_ef_a,
    input  wire datapath_pkg::port_mask_t io_write_ef_b,
    output logic                         io_ready,
    output datapath_pkg::port_mask_t     io_rden_a,
    output datapath_pkg::port_mask_t     io_rden_b,
    output datapath_pkg::port_mask_t     wr_mask_a,
    output datapath_pkg::port_mask_t     wr_mask_b,
    output datapath_pkg::alu_op_e        control_s1,
    output datapath_pkg::addr_t          read_addr_a_s1,
    output datapath_pkg::addr_t          read_addr_b_s1,
    output datapath_pkg::addr_t          write_addr_a_s1,
    output datapath_pkg::addr_t          write_addr_b_s1
);

    import datapath_pkg::*;

    port_mask_t rd_sel_a;
    port_mask_t rd_sel_b;
    port_mask_t wr_sel_a;
    port_mask_t wr_sel_b;
    logic       ready_d;

    // One-hot port select when the address lands in the I/O window, else zero
    function automatic port_mask_t port_select(input addr_t addr);
        operand_addr_u view;
        port_mask_t    sel;
        view = addr;
        sel  = '0;
        if (view.io.io_tag == `DP_IO_TAG) begin
            sel[view.io.port] = 1'b1;
        end
        return sel;
    endfunction

    // --------------------------------------------------
    // Address decode and empty/full check

    assign rd_sel_a = port_select(read_addr_a);
    assign rd_sel_b = port_select(read_addr_b);
    assign wr_sel_a = port_select(write_addr_a);
    assign wr_sel_b = port_select(write_addr_b);

    // Every selected port must be ready, and the instruction must not be cancelled
    assign ready_d = !cancel
                  && ((rd_sel_a & ~io_read_ef_a) == '0)
                  && ((rd_sel_b & ~io_read_ef_b) == '0)
                  && ((wr_sel_a & ~io_write_ef_a) == '0)
                  && ((wr_sel_b & ~io_write_ef_b) == '0);

    // --------------------------------------------------
    // Stage 1 registers

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            io_ready  <= 1'b0;
            io_rden_a <= '0;
            io_rden_b <= '0;
            wr_mask_a <= '0;
            wr_mask_b <= '0;
        end else begin
            io_ready  <= ready_d;
            // An annulled instruction pops and pushes nothing
            io_rden_a <= ready_d ? rd_sel_a : '0;
            io_rden_b <= ready_d ? rd_sel_b : '0;
            wr_mask_a <= ready_d ? wr_sel_a : '0;
            wr_mask_b <= ready_d ? wr_sel_b : '0;
        end
    end

    // Instruction fields ride along unqualified
    always_ff @(posedge clock) begin
        control_s1      <= control;
        read_addr_a_s1  <= read_addr_a;
        read_addr_b_s1  <= read_addr_b;
        write_addr_a_s1 <= write_addr_a;
        write_addr_b_s1 <= write_addr_b;
    end

    rden_a_onehot0 : assert property (
        @(posedge clock) disable iff (!arst_n) $onehot0(io_rden_a)
    );

    rden_b_onehot0 : assert property (
        @(posedge clock) disable iff (!arst_n) $onehot0(io_rden_b)
    );

endmodule

`default_nettype wire

// ==== logic/operand_bank.sv ====
// Memory contents are undefined after reset; a write lands one edge before any read can see it
`timescale 1ns/1ns
`default_nettype none

`include "datapath_cfg.svh"

module operand_bank (
    input  wire                                                    clock,
    input  wire                                                    arst_n,
    input  wire datapath_pkg::addr_t                               read_addr,
    input  wire datapath_pkg::port_mask_t                          io_rden,
    input  wire datapath_pkg::word_t [`DP_IO_PORT_COUNT-1:0]       io_read_data,
    input  wire datapath_pkg::word_t                               r,
    input  wire datapath_pkg::addr_t                               write_addr,
    input  wire                                                    r_valid,
    input  wire datapath_pkg::port_mask_t                          io_wren,
    output datapath_pkg::word_t                                    operand,
    output wire datapath_pkg::word_t [`DP_IO_PORT_COUNT-1:0]       io_write_data
);

    import datapath_pkg::*;

    // Everything below the port window is memory
    localparam int MEM_DEPTH = (1 << `DP_ADDR_WIDTH) - `DP_IO_PORT_COUNT;

    word_t         mem [MEM_DEPTH];
    operand_addr_u rd_view;
    operand_addr_u wr_view;
    word_t         port_word;
    logic          mem_we;

    assign rd_view = read_addr;
    assign wr_view = write_addr;

    // --------------------------------------------------
    // Read side

    // Popped port word, io_rden is zero or one-hot so an OR is enough
    always_comb begin
        port_word = '0;
        for (int p = 0; p < `DP_IO_PORT_COUNT; p++) begin
            if (io_rden[p]) begin
                port_word = port_word | io_read_data[p];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (io_rden != '0) begin
            operand <= port_word;
        end else if (rd_view.io.io_tag != `DP_IO_TAG) begin
            operand <= mem[rd_view.index];
        end else begin
            // Port address on an annulled instruction
            operand <= '0;
        end
    end

    // --------------------------------------------------
    // Write-back side

    // Results aimed at a port leave through io_write_data instead
    assign mem_we = r_valid && (io_wren == '0);

    always_ff @(posedge clock) begin
        if (mem_we) begin
            mem[wr_view.index] <= r;
        end
    end

    // Every port sees the result, io_wren picks who takes it
    assign io_write_data = {`DP_IO_PORT_COUNT{r}};

    // A valid result for the port window must leave as exactly one port enable,
    // which keeps it out of memory
    port_write_not_in_mem : assert property (
        @(posedge clock) disable iff (!arst_n)
        (r_valid && (wr_view.io.io_tag == `DP_IO_TAG)) |-> $onehot(io_wren)
    );

endmodule

`default_nettype wire

// ==== tests/datapath_tb.sv ====
// Only data words 0 to 15 are exercised and are filled from ports before any memory read
`timescale 1ns/1ns
`default_nettype none

`include "datapath_cfg.svh"

module datapath_tb;

    import datapath_pkg::*;

    localparam int WW            = `DP_WORD_WIDTH;
    localparam int PORTS         = `DP_IO_PORT_COUNT;
    localparam int MEM_WORDS     = (1 << `DP_ADDR_WIDTH) - PORTS;
    localparam int TEST_ADDRS    = 16;
    localparam int IDLE_CYCLES   = 6;
    localparam int RANDOM_INSTRS = 400;
    localparam int DRAIN_CYCLES  = 4;
    localparam int CYCLE_LIMIT   = 5 + IDLE_CYCLES + 3 * TEST_ADDRS + RANDOM_INSTRS
                                   + 2 * DRAIN_CYCLES + 40;

    logic              clock = 1'b0;
    logic              arst_n;
    alu_op_e           control;
    logic              cancel;
    addr_t             read_addr_a, read_addr_b, write_addr_a, write_addr_b;
    port_mask_t        io_read_ef_a, io_read_ef_b, io_write_ef_a, io_write_ef_b;
    word_t [PORTS-1:0] io_read_data_a, io_read_data_b;
    logic              io_ready;
    port_mask_t        io_rden_a, io_rden_b, io_wren_a, io_wren_b;
    word_t [PORTS-1:0] io_write_data_a, io_write_data_b;
    word_t             r;
    logic              r_valid, r_carry, r_overflow;
    addr_t             r_write_addr_a, r_write_addr_b;

    logic [31:0] lfsr_state;
    logic        ports_open;
    int          checks;
    int          errors;
    int          cycle_count = 0;

    // Reference pipeline, one set of registers per DUT stage
    logic       m1_ready;
    alu_op_e    m1_op;
    addr_t      m1_ra, m1_rb, m1_wa, m1_wb;
    port_mask_t m1_rden_a, m1_rden_b, m1_wm_a, m1_wm_b;
    logic       m2_ready;
    alu_op_e    m2_op;
    word_t      m2_a, m2_b;
    addr_t      m2_wa, m2_wb;
    port_mask_t m2_wm_a, m2_wm_b;
    logic       m3_valid, m3_carry, m3_ovf;
    word_t      m3_r;
    addr_t      m3_wa, m3_wb;
    port_mask_t m3_wm_a, m3_wm_b;
    word_t      mem_a [MEM_WORDS];
    word_t      mem_b [MEM_WORDS];
    port_mask_t popped_a, popped_b;
    word_t      next_a, next_b;

    datapath u_datapath (
        .clock (clock), .arst_n (arst_n), .control (control), .cancel (cancel),
        .read_addr_a (read_addr_a), .read_addr_b (read_addr_b),
        .write_addr_a (write_addr_a), .write_addr_b (write_addr_b),
        .io_read_ef_a (io_read_ef_a), .io_read_ef_b (io_read_ef_b),
        .io_write_ef_a (io_write_ef_a), .io_write_ef_b (io_write_ef_b),
        .io_read_data_a (io_read_data_a), .io_read_data_b (io_read_data_b),
        .io_ready (io_ready), .io_rden_a (io_rden_a), .io_rden_b (io_rden_b),
        .io_wren_a (io_wren_a), .io_wren_b (io_wren_b),
        .io_write_data_a (io_write_data_a), .io_write_data_b (io_write_data_b),
        .r (r), .r_valid (r_valid), .r_carry (r_carry), .r_overflow (r_overflow),
        .r_write_addr_a (r_write_addr_a), .r_write_addr_b (r_write_addr_b)
    );

    always #4 clock = ~clock;

    // --------------------------------------------------
    // Random numbers and address helpers

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    function automatic logic is_port(input addr_t a);
        return int'(a) >= MEM_WORDS;
    endfunction

    function automatic int port_num(input addr_t a);
        return int'(a) - MEM_WORDS;
    endfunction

    function automatic addr_t port_addr(input int p);
        return addr_t'(MEM_WORDS + p);
    endfunction

    function automatic port_mask_t port_sel(input addr_t a);
        port_mask_t m;
        m = '0;
        if (is_port(a)) begin
            m[port_num(a)] = 1'b1;
        end
        return m;
    endfunction

    // Ports are drawn one time in four, memory from the test window otherwise
    function automatic addr_t rand_addr();
        if (take_bits(2) == 0) begin
            return port_addr(int'(take_bits(2)));
        end
        return addr_t'(take_bits($clog2(TEST_ADDRS)));
    endfunction

    // --------------------------------------------------
    // Reference model

    function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b,
                                        output logic carry, output logic ovf);
        logic signed [WW:0] ss;
        word_t              res;
        carry = 1'b0;
        ovf   = 1'b0;
        case (op)
            ALU_ADD: begin
                res   = a + b;
                // The sum wraps below a exactly when the add carries out
                carry = res < a;
                ss    = $signed({a[WW-1], a}) + $signed({b[WW-1], b});
                ovf   = ss[WW] != ss[WW-1];
            end
            ALU_SUB: begin
                res   = a - b;
                carry = a >= b;
                ss    = $signed({a[WW-1], a}) - $signed({b[WW-1], b});
                ovf   = ss[WW] != ss[WW-1];
            end
            ALU_AND: res = a & b;
            ALU_OR:  res = a | b;
            ALU_XOR: res = a ^ b;
            default: res = a;
        endcase
        return res;
    endfunction

    function automatic word_t bank_read(input logic side_b, input port_mask_t rden,
                                        input addr_t addr);
        if (rden != '0) begin
            return side_b ? io_read_data_b[port_num(addr)] : io_read_data_a[port_num(addr)];
        end
        if (is_port(addr)) begin
            return '0;
        end
        return side_b ? mem_b[addr] : mem_a[addr];
    endfunction

    always @(posedge clock) begin
        if (!arst_n) begin
            m1_ready  = 1'b0;
            m1_rden_a = '0;
            m1_rden_b = '0;
            m1_wm_a   = '0;
            m1_wm_b   = '0;
            m2_ready  = 1'b0;
            m3_valid  = 1'b0;
            m3_wm_a   = '0;
            m3_wm_b   = '0;
            popped_a  = '0;
            popped_b  = '0;
        end else begin
            popped_a = m1_rden_a;
            popped_b = m1_rden_b;
            // Operand read sees memory as it was before this edge's write-back
            next_a = bank_read(1'b0, m1_rden_a, m1_ra);
            next_b = bank_read(1'b1, m1_rden_b, m1_rb);
            if (m3_valid && m3_wm_a == '0) begin
                mem_a[m3_wa] = m3_r;
            end
            if (m3_valid && m3_wm_b == '0) begin
                mem_b[m3_wb] = m3_r;
            end
            m3_valid = m2_ready;
            m3_r     = alu_model(m2_op, m2_a, m2_b, m3_carry, m3_ovf);
            m3_wa    = m2_wa;
            m3_wb    = m2_wb;
            m3_wm_a  = m2_wm_a;
            m3_wm_b  = m2_wm_b;
            m2_ready = m1_ready;
            m2_op    = m1_op;
            m2_a     = next_a;
            m2_b     = next_b;
            m2_wa    = m1_wa;
            m2_wb    = m1_wb;
            m2_wm_a  = m1_wm_a;
            m2_wm_b  = m1_wm_b;
            m1_ready = !cancel
                       && ((port_sel(read_addr_a) & ~io_read_ef_a) == '0)
                       && ((port_sel(read_addr_b) & ~io_read_ef_b) == '0)
                       && ((port_sel(write_addr_a) & ~io_write_ef_a) == '0)
                       && ((port_sel(write_addr_b) & ~io_write_ef_b) == '0);
            m1_op     = control;
            m1_ra     = read_addr_a;
            m1_rb     = read_addr_b;
            m1_wa     = write_addr_a;
            m1_wb     = write_addr_b;
            m1_rden_a = m1_ready ? port_sel(read_addr_a) : '0;
            m1_rden_b = m1_ready ? port_sel(read_addr_b) : '0;
            m1_wm_a   = m1_ready ? port_sel(write_addr_a) : '0;
            m1_wm_b   = m1_ready ? port_sel(write_addr_b) : '0;
        end
    end

    // --------------------------------------------------
    // Compare tasks

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_mask(input port_mask_t got, input port_mask_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_outputs();
        check_flag(io_ready, m1_ready, "io_ready");
        check_mask(io_rden_a, m1_rden_a, "io_rden_a");
        check_mask(io_rden_b, m1_rden_b, "io_rden_b");
        check_flag(r_valid, m3_valid, "r_valid");
        check_mask(io_wren_a, m3_wm_a, "io_wren_a");
        check_mask(io_wren_b, m3_wm_b, "io_wren_b");
        if (m3_valid) begin
            check_word(r, m3_r, "r");
            check_flag(r_carry, m3_carry, "r_carry");
            check_flag(r_overflow, m3_ovf, "r_overflow");
            check_addr(r_write_addr_a, m3_wa, "r_write_addr_a");
            check_addr(r_write_addr_b, m3_wb, "r_write_addr_b");
            for (int p = 0; p < PORTS; p++) begin
                if (m3_wm_a[p]) begin
                    check_word(io_write_data_a[p], m3_r, "io_write_data_a");
                end
                if (m3_wm_b[p]) begin
                    check_word(io_write_data_b[p], m3_r, "io_write_data_b");
                end
            end
        end
    endtask

    // --------------------------------------------------
    // Port models and stimulus

    // A popped port offers a fresh word; empty/full bits are random unless ports_open
    task automatic refresh_ports();
        for (int p = 0; p < PORTS; p++) begin
            if (popped_a[p]) begin
                io_read_data_a[p] = word_t'(take_bits(WW));
            end
            if (popped_b[p]) begin
                io_read_data_b[p] = word_t'(take_bits(WW));
            end
        end
        io_read_ef_a  = ports_open ? '1 : port_mask_t'(take_bits(PORTS));
        io_read_ef_b  = ports_open ? '1 : port_mask_t'(take_bits(PORTS));
        io_write_ef_a = ports_open ? '1 : port_mask_t'(take_bits(PORTS));
        io_write_ef_b = ports_open ? '1 : port_mask_t'(take_bits(PORTS));
    endtask

    task automatic issue(input alu_op_e op, input logic cxl, input addr_t ra, input addr_t rb,
                         input addr_t wa, input addr_t wb);
        @(negedge clock);
        compare_outputs();
        refresh_ports();
        control      = op;
        cancel       = cxl;
        read_addr_a  = ra;
        read_addr_b  = rb;
        write_addr_a = wa;
        write_addr_b = wb;
    endtask

    task automatic issue_random();
        alu_op_e op;
        logic    cxl;
        addr_t   ra, rb, wa, wb;
        op  = alu_op_e'(3'(take_bits(3) % 6));
        cxl = take_bits(3) == 0;
        ra  = rand_addr();
        rb  = rand_addr();
        wa  = rand_addr();
        wb  = rand_addr();
        issue(op, cxl, ra, rb, wa, wb);
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        lfsr_state    = 32'd85404;
        checks        = 0;
        errors        = 0;
        ports_open    = 1'b1;
        arst_n        = 1'b0;
        control       = ALU_ADD;
        cancel        = 1'b1;
        read_addr_a   = '0;
        read_addr_b   = '0;
        write_addr_a  = '0;
        write_addr_b  = '0;
        io_read_ef_a  = '0;
        io_read_ef_b  = '0;
        io_write_ef_a = '0;
        io_write_ef_b = '0;
        for (int p = 0; p < PORTS; p++) begin
            io_read_data_a[p] = word_t'(take_bits(WW));
            io_read_data_b[p] = word_t'(take_bits(WW));
        end
        repeat (4) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        // Cancelled instructions on ready ports must stay silent
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            issue(ALU_ADD, 1'b1, port_addr(0), port_addr(1), port_addr(2), port_addr(3));
        end
        // Fill both banks from port words
        for (int a = 0; a < TEST_ADDRS; a++) begin
            issue(ALU_PASS_A, 1'b0, port_addr(0), port_addr(0), addr_t'(a), addr_t'(a));
        end
        // Let the last fill writes land before random reads
        for (int i = 0; i < DRAIN_CYCLES; i++) begin
            issue(ALU_ADD, 1'b1, '0, '0, '0, '0);
        end
        ports_open = 1'b0;
        for (int i = 0; i < RANDOM_INSTRS; i++) begin
            issue_random();
        end
        // Read back through output ports, bank B via xor with bank A
        ports_open = 1'b1;
        for (int a = 0; a < TEST_ADDRS; a++) begin
            issue(ALU_PASS_A, 1'b0, addr_t'(a), addr_t'(a), port_addr(0), port_addr(0));
            issue(ALU_XOR, 1'b0, addr_t'(a), addr_t'(a), port_addr(1), port_addr(1));
        end
        for (int i = 0; i < DRAIN_CYCLES; i++) begin
            issue(ALU_ADD, 1'b1, '0, '0, '0, '0);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
